//--- Makefile
# Verilator build and run of the rv_core testbench

VERILATOR ?= verilator
TOP       ?= rv_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

//--- decoder.sv
//##########################################################################
// Combinational RV32 decoder for addi, auipc, jal and ebreak
// Anything else is reported through inst_not_ipl
//##########################################################################

`timescale 1ns/10ps

`include "rv_cfg.svh"

module decoder (
  input  logic [`INST_WIDTH-1:0]   inst,
  output logic [`REG_ID_WIDTH-1:0] rd,
  output logic [`REG_ID_WIDTH-1:0] rs1,
  output logic [`IMM_WIDTH-1:0]    imm,
  output logic                     need_imm,     // Second ALU operand is imm
  output logic                     alu_add,      // Writes an adder result
  output logic                     is_auipc,
  output logic                     is_jal,
  output logic                     is_ebreak,
  output logic                     inst_not_ipl  // Outside the subset
);

  import rv_pkg::*;

  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [11:0]           funct12;
  logic                  op_imm;
  logic                  op_auipc;
  logic                  op_jal;
  logic                  op_system;
  logic                  addi;
  logic                  ebreak;
  logic [`IMM_WIDTH-1:0] imm_i;
  logic [`IMM_WIDTH-1:0] imm_u;
  logic [`IMM_WIDTH-1:0] imm_j;

  // Fixed field positions
  assign opcode  = opcode_e'(inst[6:0]);
  assign funct3  = inst[14:12];
  assign funct12 = inst[31:20];
  assign rd      = inst[11:7];
  assign rs1     = inst[19:15];

  assign op_imm    = (opcode == OP_IMM);
  assign op_auipc  = (opcode == AUIPC);
  assign op_jal    = (opcode == JAL);
  assign op_system = (opcode == SYSTEM);

  assign addi   = op_imm & (funct3 == F3_ADDI);
  // ebreak also needs rd and rs1 zero
  assign ebreak = op_system & (funct3 == F3_PRIV) & (funct12 == F12_EBREAK)
                & (rd == '0) & (rs1 == '0);

  // Immediate formats, all sign-extended from bit 31
  assign imm_i = `IMM_WIDTH'($signed(inst[31:20]));
  assign imm_u = `IMM_WIDTH'($signed({inst[31:12], 12'b0}));
  assign imm_j = `IMM_WIDTH'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));

  // One-hot select, zero for unsupported words
  assign imm = ({`IMM_WIDTH{addi}}     & imm_i)
             | ({`IMM_WIDTH{op_auipc}} & imm_u)
             | ({`IMM_WIDTH{op_jal}}   & imm_j);

  assign need_imm     = addi | op_auipc;  // jal adds 4 for its link value
  assign alu_add      = addi | op_auipc;
  assign is_auipc     = op_auipc;
  assign is_jal       = op_jal;
  assign is_ebreak    = ebreak;
  assign inst_not_ipl = ~(addi | op_auipc | op_jal | ebreak);

endmodule

//--- exec_unit.sv
//##########################################################################
// Execute stage: pops the queue, decodes, updates the register file,
// redirects fetch on jal, halts on ebreak and reports each retirement
//##########################################################################

`timescale 1ns/10ps

`include "rv_cfg.svh"

module exec_unit (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     empty,
  input  rv_pkg::fetch_t           head_entry,
  output logic                     pop,
  output logic                     redirect,     // 1-cycle jal strobe
  output logic [`INST_WIDTH-1:0]   redirect_pc,
  output logic                     halted,       // Sticky until reset
  output logic                     retire,
  output logic                     wb_en,
  output logic [`INST_WIDTH-1:0]   retire_pc,
  output logic [`INST_WIDTH-1:0]   wb_data,
  output logic [`REG_ID_WIDTH-1:0] wb_rd,
  output logic                     unimpl
);

  import rv_pkg::*;

  localparam int NUM_REGS = 2 ** `REG_ID_WIDTH;

  logic [`INST_WIDTH-1:0]   regs [NUM_REGS];  // x0 slot never written
  logic [`REG_ID_WIDTH-1:0] rd;
  logic [`REG_ID_WIDTH-1:0] rs1;
  logic [`IMM_WIDTH-1:0]    imm;
  logic                     need_imm;
  logic                     alu_add;
  logic                     is_auipc;
  logic                     is_jal;
  logic                     is_ebreak;
  logic                     inst_not_ipl;
  logic [`INST_WIDTH-1:0]   rs1_val;
  logic [`INST_WIDTH-1:0]   op_a;
  logic [`INST_WIDTH-1:0]   op_b;
  logic [`INST_WIDTH-1:0]   result;
  logic                     wr_en;

  decoder dec0 (
    .inst(head_entry.inst), .rd(rd), .rs1(rs1), .imm(imm), .need_imm(need_imm),
    .alu_add(alu_add), .is_auipc(is_auipc), .is_jal(is_jal),
    .is_ebreak(is_ebreak), .inst_not_ipl(inst_not_ipl)
  );

  assign pop = ~empty & ~halted;                      // One per cycle

  assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];      // x0 reads zero
  assign op_a    = (is_auipc | is_jal) ? head_entry.pc : rs1_val;
  assign op_b    = need_imm ? imm : PC_STEP;          // jal link is pc + 4
  assign result  = op_a + op_b;

  assign wr_en       = pop & (alu_add | is_jal) & (rd != '0);
  assign redirect    = pop & is_jal;
  assign redirect_pc = head_entry.pc + imm;           // jal target

  // Register file, written at the pop edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd] <= result;
    end
  end

  // Retire control and halt
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      retire <= 1'b0;
      wb_en  <= 1'b0;
      unimpl <= 1'b0;
      halted <= 1'b0;
    end else begin
      retire <= pop;
      wb_en  <= wr_en;
      unimpl <= pop & inst_not_ipl;     // Retires as a no-op
      if (pop && is_ebreak) halted <= 1'b1;
    end
  end

  // Retire payload, qualified by retire / wb_en
  always_ff @(posedge clk) begin
    if (pop) begin
      retire_pc <= head_entry.pc;
      wb_rd     <= rd;
      wb_data   <= result;
    end
  end

endmodule

//--- fetch_unit.sv
//##########################################################################
// Fetch stage: owns the pc, addresses instruction memory and pushes
// pc/instruction pairs into the queue until full, redirect or halt
//##########################################################################

`timescale 1ns/10ps

`include "rv_cfg.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   full,         // Queue cannot take an entry
  input  logic                   redirect,     // jal taken in execute
  input  logic [`INST_WIDTH-1:0] redirect_pc,  // jal target
  input  logic                   halted,       // ebreak seen, stop fetching
  input  logic [`INST_WIDTH-1:0] imem_data,    // Combinational memory read
  output logic [`INST_WIDTH-1:0] imem_addr,
  output logic                   push,
  output rv_pkg::fetch_t         push_entry
);

  import rv_pkg::*;

  logic [`INST_WIDTH-1:0] pc;       // Address of the word being fetched
  logic [`INST_WIDTH-1:0] pc_next;  // Sequential successor

  assign imem_addr = pc;              // Memory answers in the same cycle
  assign pc_next   = pc + PC_STEP;

  // Redirect kills this cycle's fetch, the queue flushes anyway
  assign push = ~full & ~halted & ~redirect;

  assign push_entry.pc   = pc;
  assign push_entry.inst = imem_data;

  // Program counter
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RESET_PC;
    end else if (redirect) begin
      pc <= redirect_pc;      // Jump overrides increment
    end else if (push) begin
      pc <= pc_next;          // Advance only when the word was taken
    end
    // Full or halted, pc holds
  end

endmodule

//--- inst_queue.sv
//##########################################################################
// Circular FIFO of fetch entries between fetch and execute
// Head is shown while not empty; flush on redirect empties it at once
//##########################################################################

`timescale 1ns/10ps

`include "rv_cfg.svh"

module inst_queue (
  input  logic           clk,
  input  logic           arst_n,
  input  logic           push,        // Write push_entry at this edge
  input  rv_pkg::fetch_t push_entry,
  input  logic           pop,         // Drop head at this edge
  input  logic           flush,       // Empties the queue and beats push
  output rv_pkg::fetch_t head_entry,
  output logic           full,
  output logic           empty
);

  import rv_pkg::*;

  localparam int PTR_W = $clog2(`QUEUE_DEPTH);

  fetch_t           slots [`QUEUE_DEPTH];  // Payload slots
  logic [PTR_W-1:0] rd_ptr;                // Head slot
  logic [PTR_W-1:0] wr_ptr;                // Next free slot
  logic [PTR_W:0]   count;                 // Occupancy from 0 to QUEUE_DEPTH

  assign full       = (count == (PTR_W+1)'(`QUEUE_DEPTH));
  assign empty      = (count == '0);
  assign head_entry = slots[rd_ptr];       // Valid only while not empty

  // Entry storage
  always_ff @(posedge clk) begin
    if (push && !flush) begin
      slots[wr_ptr] <= push_entry;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      rd_ptr <= '0;           // Simultaneous push is lost
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Both or neither
      endcase
    end
  end

endmodule

//--- rv_cfg.svh
//##########################################################################
// Build-time constants for the RV32 fetch-decode-execute core
// Included by the package, the RTL and the testbench
//##########################################################################

`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// Instruction and datapath width
`define INST_WIDTH 32

// Register index width, 32 architectural registers
`define REG_ID_WIDTH 5

// Width of the sign-extended immediate
`define IMM_WIDTH 32

// Instruction queue entries, power of two only
`define QUEUE_DEPTH 4

// First fetch address out of reset
`define RESET_PC 32'h0000_0000

`endif

//--- rv_core.sv
//##########################################################################
// Core top: fetch unit feeding the instruction queue feeding execute
// Instruction memory is external and read combinationally
//##########################################################################

`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_core (
  input  logic                     clk,
  input  logic                     arst_n,
  output logic [`INST_WIDTH-1:0]   imem_addr,
  input  logic [`INST_WIDTH-1:0]   imem_data,
  output logic                     retire,      // 1-cycle per instruction
  output logic [`INST_WIDTH-1:0]   retire_pc,
  output logic                     wb_en,
  output logic [`REG_ID_WIDTH-1:0] wb_rd,
  output logic [`INST_WIDTH-1:0]   wb_data,
  output logic                     unimpl,
  output logic                     halted
);

  import rv_pkg::*;

  fetch_t                 push_entry;
  fetch_t                 head_entry;
  logic                   push;
  logic                   pop;
  logic                   full;
  logic                   empty;
  logic                   redirect;      // Also flushes the queue
  logic [`INST_WIDTH-1:0] redirect_pc;

  fetch_unit fetch0 (
    .clk(clk), .arst_n(arst_n), .full(full), .redirect(redirect),
    .redirect_pc(redirect_pc), .halted(halted), .imem_data(imem_data),
    .imem_addr(imem_addr), .push(push), .push_entry(push_entry)
  );

  inst_queue queue0 (
    .clk(clk), .arst_n(arst_n), .push(push), .push_entry(push_entry),
    .pop(pop), .flush(redirect), .head_entry(head_entry),
    .full(full), .empty(empty)
  );

  exec_unit exec0 (
    .clk(clk), .arst_n(arst_n), .empty(empty), .head_entry(head_entry),
    .pop(pop), .redirect(redirect), .redirect_pc(redirect_pc),
    .halted(halted), .retire(retire), .wb_en(wb_en), .retire_pc(retire_pc),
    .wb_data(wb_data), .wb_rd(wb_rd), .unimpl(unimpl)
  );

endmodule

//--- rv_core_assertions.sv
//##########################################################################
// Concurrent checks on queue occupancy, halt and redirect
// Bound into inst_queue and exec_unit by the bind lines below
//##########################################################################

`timescale 1ns/10ps

module rv_core_assertions (
  input logic clk,
  input logic arst_n,
  input logic push,
  input logic pop,
  input logic full,
  input logic empty,
  input logic halted,
  input logic redirect
);

  int unsigned fail_count = 0;  // Failed assertion count

  push_not_full: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
    else begin
      $error("queue pushed while full");
      fail_count++;
    end

  pop_not_empty: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
    else begin
      $error("queue popped while empty");
      fail_count++;
    end

  halt_sticky: assert property (@(posedge clk) disable iff (!arst_n) halted |=> halted)
    else begin
      $error("halted fell before reset");
      fail_count++;
    end

  redirect_once: assert property (@(posedge clk) disable iff (!arst_n) redirect |=> !redirect)
    else begin
      $error("redirect held longer than one cycle");
      fail_count++;
    end

endmodule

bind inst_queue rv_core_assertions queue_chk (
  .clk(clk), .arst_n(arst_n), .push(push), .pop(pop), .full(full),
  .empty(empty), .halted(1'b0), .redirect(flush)
);

bind exec_unit rv_core_assertions exec_chk (
  .clk(clk), .arst_n(arst_n), .push(1'b0), .pop(pop), .full(1'b0),
  .empty(empty), .halted(halted), .redirect(redirect)
);

//--- rv_core_tb.sv
//##########################################################################
// Testbench for rv_core with an LFSR-built program in local memory
// A reference ISS model is checked on every retire until ebreak halts
//##########################################################################

`timescale 1ns/10ps

`include "rv_cfg.svh"

module rv_core_tb;

  import rv_pkg::*;

  localparam int          PROG_WORDS     = 64;
  localparam int          TIMEOUT_CYCLES = PROG_WORDS * (`QUEUE_DEPTH + 4);
  localparam logic [31:0] EBREAK_WORD    = 32'h0010_0073;
  localparam logic [6:0]  OP_REG         = 7'b0110011;  // R-type major opcode

  logic        clk = 1'b0;
  logic        arst_n;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic        retire;
  logic [31:0] retire_pc;
  logic        wb_en;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        unimpl;
  logic        halted;

  logic [31:0] prog [PROG_WORDS];  // Program image
  logic [31:0] lfsr_state;
  logic [31:0] ref_regs [32];      // Model register file
  logic [31:0] ref_pc;             // Model pc of the next retire
  logic        exp_wb;
  logic [4:0]  exp_rd;
  logic [31:0] exp_data;
  logic        exp_unimpl;
  logic        exp_halt;
  logic        halt_seen = 1'b0;
  int unsigned cycle_count = 0;
  int unsigned assert_fails;

  rv_core dut0 (
    .clk(clk), .arst_n(arst_n), .imem_addr(imem_addr), .imem_data(imem_data),
    .retire(retire), .retire_pc(retire_pc), .wb_en(wb_en), .wb_rd(wb_rd),
    .wb_data(wb_data), .unimpl(unimpl), .halted(halted)
  );

  always #20 clk = ~clk;  // 40 ns period

  // Fetches past the image see an R-type word folded from the whole address
  function automatic logic [31:0] outside_word(input logic [31:0] addr);
    return {addr[31:7] ^ {addr[6:0], 18'b0}, OP_REG};
  endfunction

  // Memory answers imem_addr in the same cycle
  assign imem_data = (imem_addr < 32'(PROG_WORDS * 4)) ? prog[imem_addr[7:2]]
                                                     : outside_word(imem_addr);
  assign assert_fails = dut0.queue0.queue_chk.fail_count + dut0.exec0.exec_chk.fail_count;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      val        = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  task automatic build_program();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [31:0] field;
    logic [20:0] joff;
    int          hop;
    for (int i = 0; i < PROG_WORDS - 1; i++) begin
      kind = 4'(take_bits(4));
      rd   = 5'(take_bits(5));
      if (kind < 4'd7) begin
        field   = take_bits(17);                         // imm12 and rs1
        prog[i] = {field[16:0], 3'b000, rd, OP_IMM};
      end else if (kind < 4'd12) begin
        field   = take_bits(20);
        prog[i] = {field[19:0], rd, AUIPC};
      end else if (kind < 4'd14 && i < PROG_WORDS - 2) begin
        hop = 1 + int'(take_bits(2));                    // Forward 1..4 words
        if (i + hop > PROG_WORDS - 1) hop = PROG_WORDS - 1 - i;
        joff    = 21'(hop * 4);
        prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, JAL};
      end else begin
        field   = take_bits(25);
        prog[i] = {field[24:0], OP_REG};                 // Register-register op
      end
    end
    prog[PROG_WORDS-1] = EBREAK_WORD;
  endtask

  // Executes the word at ref_pc on the model state
  function automatic void iss_step(input logic [31:0] inst, output logic e_wb,
                                   output logic [4:0] e_rd, output logic [31:0] e_data,
                                   output logic e_unimpl, output logic e_halt);
    opcode_e     op;
    logic [31:0] next_pc;
    logic [31:0] src;
    op       = opcode_e'(inst[6:0]);
    next_pc  = ref_pc + 32'd4;
    src      = ref_regs[inst[19:15]];                   // Entry 0 stays zero
    e_rd     = inst[11:7];
    e_data   = '0;
    e_wb     = 1'b0;
    e_unimpl = 1'b0;
    e_halt   = 1'b0;
    case (op)
      OP_IMM: begin
        e_unimpl = (inst[14:12] != 3'b000);
        e_wb     = ~e_unimpl;
        e_data   = src + {{20{inst[31]}}, inst[31:20]};
      end
      AUIPC: begin
        e_wb   = 1'b1;
        e_data = ref_pc + {inst[31:12], 12'b0};
      end
      JAL: begin
        e_wb    = 1'b1;
        e_data  = ref_pc + 32'd4;                          // Link value
        next_pc = ref_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                            inst[30:21], 1'b0};
      end
      SYSTEM:  e_halt = (inst == EBREAK_WORD);
      default: e_halt = 1'b0;
    endcase
    if (!(e_wb || e_halt)) e_unimpl = 1'b1;                // Retires as a no-op
    if (e_rd == 5'd0) e_wb = 1'b0;
    if (e_wb) ref_regs[e_rd] = e_data;
    ref_pc = next_pc;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error: %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "mismatch on %s", what);
    end
  endtask

  // Retired values are compared at the falling edge
  always @(negedge clk) begin
    if (arst_n === 1'b1) begin
      if (assert_fails != 0) begin
        $display("a bound assertion on the core failed, see the message above");
        $display("Result: FAILED");
        $fatal(1, "assertion failure");
      end
      if (halt_seen) begin
        check_value(32'(retire), 32'd0, "retire after halt");
        check_value(32'(halted), 32'd1, "halted after ebreak");
      end else if (retire) begin
        check_value(retire_pc, ref_pc, "retire_pc");
        iss_step(prog[ref_pc[7:2]], exp_wb, exp_rd, exp_data, exp_unimpl, exp_halt);
        check_value(32'(wb_en), 32'(exp_wb), "wb_en");
        check_value(32'(unimpl), 32'(exp_unimpl), "unimpl");
        check_value(32'(halted), 32'(exp_halt), "halted");
        if (exp_wb) begin
          check_value(32'(wb_rd), 32'(exp_rd), "wb_rd");
          check_value(wb_data, exp_data, "wb_data");
        end
        halt_seen = exp_halt;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: ebreak did not retire within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $fatal(1, "simulation timed out");
    end
  end

  initial begin
    arst_n     = 1'b0;
    lfsr_state = 32'hc33d;
    ref_pc     = `RESET_PC;
    foreach (ref_regs[i]) ref_regs[i] = '0;
    build_program();
    repeat (2) @(posedge clk);
    #2 arst_n = 1'b1;                                      // Release after 2 cycles
    @(negedge clk);
    check_value(32'(retire), 32'd0, "retire after reset");
    check_value(32'(wb_en), 32'd0, "wb_en after reset");
    check_value(32'(unimpl), 32'd0, "unimpl after reset");
    check_value(32'(halted), 32'd0, "halted after reset");
    wait (halt_seen);
    repeat (8) @(negedge clk);                              // Quiet tail after halt
    if (halted === 1'b1 && assert_fails == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("core did not stay halted or an assertion fired near the end");
      $display("Result: FAILED");
      $fatal(1, "final state wrong");
    end
  end

endmodule

//--- rv_pkg.sv
//##########################################################################
// Shared types for the core: fetch entry and the RV32 opcode map
// Imported by fetch, queue, execute, decoder and the testbench
//##########################################################################

`include "rv_cfg.svh"

package rv_pkg;

  // One queue slot: the fetch address and the word read there
  typedef struct packed {
    logic [`INST_WIDTH-1:0] pc;    // Fetch address
    logic [`INST_WIDTH-1:0] inst;  // Raw instruction word
  } fetch_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,  // Register-immediate ALU
    AUIPC  = 7'b0010111,  // Add upper immediate to pc
    JAL    = 7'b1101111,  // Jump and link
    SYSTEM = 7'b1110011   // ecall / ebreak / csr
  } opcode_e;

  // Minor field values
  localparam logic [2:0]  F3_ADDI    = 3'b000;         // addi under OP_IMM
  localparam logic [2:0]  F3_PRIV    = 3'b000;         // Privileged group under SYSTEM
  localparam logic [11:0] F12_EBREAK = 12'h001;        // ebreak in funct12

  // Fixed pc step per instruction
  localparam logic [`INST_WIDTH-1:0] PC_STEP = `INST_WIDTH'(4);

endpackage

//--- vlog.f
+incdir+.
rv_pkg.sv
fetch_unit.sv
inst_queue.sv
decoder.sv
exec_unit.sv
rv_core.sv
rv_core_assertions.sv
rv_core_tb.sv
